// ==== source/autocat_pkg.sv ====
package autocat_pkg;

    // width of every hit count and prefix sum
    localparam int COUNT_WIDTH = 32;

    // one per-way or accumulated hit count
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // default configuration, overridden from the top level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cache associativity
    localparam int DEFAULT_NUM_WAYS = 16;

    // 2^20 accesses per epoch, roughly one million
    localparam int DEFAULT_EPOCH_POWER = 20;

    // hits the suggested partition may give up against the full cache
    localparam int DEFAULT_ALLOWED_GAP = 500;

endpackage

// ==== source/access_epoch_counter.sv ====
`timescale 1ns/1ns

module access_epoch_counter
    import autocat_pkg::*;
#(
    parameter int EPOCH_POWER = DEFAULT_EPOCH_POWER
)
(
    input  logic clk_in,
    input  logic reset_with_request_limit,
    input  logic access_valid,
    output logic epoch_end
);

    // one extra bit so the count can hold 2^EPOCH_POWER itself
    localparam logic [EPOCH_POWER:0] EPOCH_LIMIT = {1'b1, {EPOCH_POWER{1'b0}}};

    logic                 access_valid_prev;
    logic [EPOCH_POWER:0] access_count;
    logic                 access_start;

    // a held valid counts only on its leading edge
    assign access_start = access_valid & ~access_valid_prev;

    // high for exactly one cycle since the count clears on the next edge
    assign epoch_end = (access_count == EPOCH_LIMIT);

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            access_count      <= '0;
            access_valid_prev <= 1'b0;
        end
        else if (epoch_end)
        begin
            // epoch boundary, start over
            access_count      <= '0;
            access_valid_prev <= 1'b0;
        end
        else
        begin
            access_valid_prev <= access_valid;
            if (access_start)
            begin
                access_count <= access_count + 1'b1;
            end
        end
    end

endmodule

// ==== source/way_hit_counters.sv ====
`timescale 1ns/1ns

module way_hit_counters
    import autocat_pkg::*;
#(
    parameter int NUM_WAYS = DEFAULT_NUM_WAYS
)
(
    input  logic                clk_in,
    input  logic                reset_with_request_limit,
    input  logic [NUM_WAYS-1:0] hit_vec,
    input  logic                epoch_end,
    output count_t              hit_counts [NUM_WAYS]
);

    logic [NUM_WAYS-1:0] hit_vec_prev;
    logic [NUM_WAYS-1:0] hit_start;

    // rising edge per way against the previous cycle
    assign hit_start = hit_vec & ~hit_vec_prev;

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            hit_vec_prev <= '0;
        end
        else if (epoch_end)
        begin
            // an edge landing here is dropped along with the old epoch
            hit_vec_prev <= '0;
        end
        else
        begin
            hit_vec_prev <= hit_vec;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        always_ff @(posedge clk_in or posedge reset_with_request_limit)
        begin
            if (reset_with_request_limit)
            begin
                hit_counts[w] <= '0;
            end
            else if (epoch_end)
            begin
                hit_counts[w] <= '0;
            end
            else if (hit_start[w])
            begin
                hit_counts[w] <= hit_counts[w] + 1'b1;
            end
        end
    end

endmodule

// ==== source/count_sorter.sv ====
`timescale 1ns/1ns

module count_sorter
    import autocat_pkg::*;
#(
    parameter int NUM_WAYS = DEFAULT_NUM_WAYS
)
(
    input  logic   clk_in,
    input  logic   reset_with_request_limit,
    input  logic   in_valid,
    input  count_t in_counts [NUM_WAYS],
    output logic   out_valid,
    output count_t out_counts [NUM_WAYS]
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // odd-even transposition network
    // NUM_WAYS registered rounds fully sort NUM_WAYS values
    // larger values move towards index 0
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // stage_data[0] is the input, stage_data[s+1] the register after round s
    count_t              stage_data  [NUM_WAYS+1][NUM_WAYS];
    count_t              stage_swap  [NUM_WAYS][NUM_WAYS];
    logic   [NUM_WAYS:0] stage_valid;

    assign stage_data[0] = in_counts;
    assign stage_valid[0] = in_valid;

    for (genvar s = 0; s < NUM_WAYS; s++)
    begin : g_round
        // even rounds pair (0,1),(2,3)..., odd rounds pair (1,2),(3,4)...
        localparam int FIRST = s % 2;

        always_comb
        begin
            stage_swap[s] = stage_data[s];
            for (int i = FIRST; i + 1 < NUM_WAYS; i += 2)
            begin
                if (stage_data[s][i+1] > stage_data[s][i])
                begin
                    stage_swap[s][i]   = stage_data[s][i+1];
                    stage_swap[s][i+1] = stage_data[s][i];
                end
            end
        end

        always_ff @(posedge clk_in)
        begin
            stage_data[s+1] <= stage_swap[s];
        end

        always_ff @(posedge clk_in or posedge reset_with_request_limit)
        begin
            if (reset_with_request_limit)
            begin
                stage_valid[s+1] <= 1'b0;
            end
            else
            begin
                stage_valid[s+1] <= stage_valid[s];
            end
        end
    end

    assign out_counts = stage_data[NUM_WAYS];
    assign out_valid  = stage_valid[NUM_WAYS];

endmodule

// ==== source/partition_selector.sv ====
`timescale 1ns/1ns

module partition_selector
    import autocat_pkg::*;
#(
    parameter int NUM_WAYS    = DEFAULT_NUM_WAYS,
    parameter int SCALE_SHIFT = DEFAULT_EPOCH_POWER - 4,
    parameter int ALLOWED_GAP = DEFAULT_ALLOWED_GAP
)
(
    input  logic                clk_in,
    input  logic                reset_with_request_limit,
    input  logic                epoch_end,
    input  count_t              hit_counts [NUM_WAYS],
    output logic [NUM_WAYS-1:0] suggested_waymask,
    output logic                waymask_update
);

    localparam int INDEX_WIDTH = $clog2(NUM_WAYS);
    localparam logic [COUNT_WIDTH:0] GAP = (COUNT_WIDTH+1)'(ALLOWED_GAP);

    logic                   snap_valid;
    count_t                 snap_counts   [NUM_WAYS];
    logic                   sorted_valid;
    count_t                 sorted_counts [NUM_WAYS];
    count_t                 prefix_d      [NUM_WAYS];
    count_t                 prefix_q      [NUM_WAYS];
    logic                   prefix_valid;
    logic [INDEX_WIDTH-1:0] best_index;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // snapshot and sort
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_in)
    begin
        if (epoch_end)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                snap_counts[w] <= hit_counts[w] >> SCALE_SHIFT;
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            snap_valid     <= 1'b0;
            prefix_valid   <= 1'b0;
            waymask_update <= 1'b0;
        end
        else
        begin
            snap_valid     <= epoch_end;
            prefix_valid   <= sorted_valid;
            waymask_update <= prefix_valid;
        end
    end

    count_sorter #(
        .NUM_WAYS (NUM_WAYS)
    ) count_sorter_inst (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .in_valid                 (snap_valid),
        .in_counts                (snap_counts),
        .out_valid                (sorted_valid),
        .out_counts               (sorted_counts)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // prefix sums, busiest way first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        prefix_d[0] = sorted_counts[0];
        for (int i = 1; i < NUM_WAYS; i++)
        begin
            prefix_d[i] = prefix_d[i-1] + sorted_counts[i];
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (sorted_valid)
        begin
            prefix_q <= prefix_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // gap search and mask
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // scan downwards so the lowest qualifying index wins,
    // the last entry always qualifies
    always_comb
    begin
        best_index = INDEX_WIDTH'(NUM_WAYS - 1);
        for (int i = NUM_WAYS - 1; i >= 0; i--)
        begin
            if ({1'b0, prefix_q[i]} + GAP >= {1'b0, prefix_q[NUM_WAYS-1]})
            begin
                best_index = INDEX_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            suggested_waymask <= '1;
        end
        else if (prefix_valid)
        begin
            for (int i = 0; i < NUM_WAYS; i++)
            begin
                suggested_waymask[i] <= (i <= int'(best_index));
            end
        end
    end

endmodule

// ==== source/autocat_top.sv ====
`timescale 1ns/1ns

module autocat_top
    import autocat_pkg::*;
#(
    parameter int NUM_WAYS    = DEFAULT_NUM_WAYS,
    parameter int EPOCH_POWER = DEFAULT_EPOCH_POWER,
    parameter int ALLOWED_GAP = DEFAULT_ALLOWED_GAP
)
(
    input  logic                clk_in,
    input  logic                reset_with_request_limit,
    input  logic                access_valid,
    input  logic [NUM_WAYS-1:0] hit_vec,
    output logic [NUM_WAYS-1:0] suggested_waymask,
    output logic                waymask_update
);

    // counts are normalised to a 16-access epoch before sorting
    localparam int SCALE_SHIFT = EPOCH_POWER - 4;

    logic   epoch_end;
    count_t hit_counts [NUM_WAYS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // epoch tracking and per-way statistics
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    access_epoch_counter #(
        .EPOCH_POWER (EPOCH_POWER)
    ) access_epoch_counter_inst (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_valid             (access_valid),
        .epoch_end                (epoch_end)
    );

    way_hit_counters #(
        .NUM_WAYS (NUM_WAYS)
    ) way_hit_counters_inst (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .hit_vec                  (hit_vec),
        .epoch_end                (epoch_end),
        .hit_counts               (hit_counts)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // partition decision, NUM_WAYS+3 cycles behind epoch_end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    partition_selector #(
        .NUM_WAYS    (NUM_WAYS),
        .SCALE_SHIFT (SCALE_SHIFT),
        .ALLOWED_GAP (ALLOWED_GAP)
    ) partition_selector_inst (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .epoch_end                (epoch_end),
        .hit_counts               (hit_counts),
        .suggested_waymask        (suggested_waymask),
        .waymask_update           (waymask_update)
    );

endmodule

// ==== verif/autocat_ref.svh ====
`ifndef AUTOCAT_REF_SVH
`define AUTOCAT_REF_SVH

// expected mask from the raw per-way hit counts of one epoch
// busiest ways are kept first, fewest ways whose hits reach the total within the gap
function automatic logic [NUM_WAYS-1:0] expected_waymask(input int unsigned hits [NUM_WAYS]);
    longint unsigned     scaled [NUM_WAYS];
    longint unsigned     total;
    longint unsigned     kept;
    longint unsigned     tmp;
    int                  n;
    logic [NUM_WAYS-1:0] mask;

    total = 0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
        scaled[w] = hits[w] >> SCALE_SHIFT;
        total     = total + scaled[w];
    end

    // selection sort, largest first
    for (int i = 0; i < NUM_WAYS - 1; i++)
    begin
        for (int j = i + 1; j < NUM_WAYS; j++)
        begin
            if (scaled[j] > scaled[i])
            begin
                tmp       = scaled[i];
                scaled[i] = scaled[j];
                scaled[j] = tmp;
            end
        end
    end

    // always at least one way
    kept = scaled[0];
    n    = 1;
    while (kept + ALLOWED_GAP < total && n < NUM_WAYS)
    begin
        kept = kept + scaled[n];
        n    = n + 1;
    end

    mask = '0;
    for (int w = 0; w < n; w++)
    begin
        mask[w] = 1'b1;
    end
    return mask;
endfunction

`endif

// ==== verif/autocat_tb.sv ====
`timescale 1ns/1ns

module autocat_tb;

    localparam int NUM_WAYS        = 16;
    localparam int EPOCH_POWER     = 6;
    localparam int ALLOWED_GAP     = 2;
    localparam int SCALE_SHIFT     = EPOCH_POWER - 4;
    localparam int EPOCH_ACCESSES  = 1 << EPOCH_POWER;
    localparam int CLK_PERIOD      = 10;
    localparam int NUM_EPOCHS      = 15;
    localparam int WATCHDOG_CYCLES = NUM_EPOCHS * EPOCH_ACCESSES * 4 + 2000;

    logic                clk_in;
    logic                reset_with_request_limit;
    logic                access_valid;
    logic [NUM_WAYS-1:0] hit_vec;
    logic [NUM_WAYS-1:0] suggested_waymask;
    logic                waymask_update;

    // testbench bookkeeping
    longint              edge_count = 0;
    int unsigned         hit_total [NUM_WAYS];
    int                  access_total;
    logic                valid_seen;
    logic [NUM_WAYS-1:0] hit_seen;
    logic [NUM_WAYS-1:0] hit_rise;
    bit                  skip_cycle;
    logic [NUM_WAYS-1:0] mask_q [$];
    longint              due_q [$];
    logic [NUM_WAYS-1:0] exp_mask;
    longint              exp_due;
    int                  error_count = 0;
    int                  check_count = 0;
    int                  seed = 72;

    `include "autocat_ref.svh"

    autocat_top #(
        .NUM_WAYS    (NUM_WAYS),
        .EPOCH_POWER (EPOCH_POWER),
        .ALLOWED_GAP (ALLOWED_GAP)
    ) autocat_top_inst (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_valid             (access_valid),
        .hit_vec                  (hit_vec),
        .suggested_waymask        (suggested_waymask),
        .waymask_update           (waymask_update)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    always @(posedge clk_in)
    begin
        edge_count <= edge_count + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers, called just after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [NUM_WAYS-1:0] way_bit(input int way);
        logic [NUM_WAYS-1:0] bits;
        bits = '0;
        if (way >= 0 && way < NUM_WAYS)
        begin
            bits[way] = 1'b1;
        end
        return bits;
    endfunction

    task automatic hold_inputs(input logic valid, input logic [NUM_WAYS-1:0] hits, input int cycles);
        access_valid <= valid;
        hit_vec      <= hits;
        repeat (cycles) @(posedge clk_in);
    endtask

    // one access with an optional hit, then at least one idle cycle
    task automatic pulse_access(input int way, input int idle_extra);
        hold_inputs(1'b1, way_bit(way), 1);
        hold_inputs(1'b0, '0, 1 + idle_extra);
    endtask

    task automatic apply_reset(input int cycles);
        reset_with_request_limit <= 1'b1;
        access_valid             <= 1'b0;
        hit_vec                  <= '0;
        repeat (cycles) @(posedge clk_in);
        reset_with_request_limit <= 1'b0;
        @(posedge clk_in);
    endtask

    task automatic check_idle_state();
        @(negedge clk_in);
        check_count++;
        if (suggested_waymask !== '1)
        begin
            $display("FAILED t=%0t suggested_waymask expected=%h actual=%h",
                     $time, {NUM_WAYS{1'b1}}, suggested_waymask);
            error_count++;
        end
        if (waymask_update !== 1'b0)
        begin
            $display("FAILED t=%0t waymask_update expected=0 actual=%b", $time, waymask_update);
            error_count++;
        end
        @(posedge clk_in);
    endtask

    task automatic wait_for_updates();
        while (due_q.size() != 0)
        begin
            @(posedge clk_in);
        end
    endtask

    task automatic run_random_epoch(input int accesses);
        int unsigned rnd;
        int          way;
        for (int i = 0; i < accesses; i++)
        begin
            rnd = $random(seed);
            way = rnd % (NUM_WAYS + 1);
            rnd = $random(seed);
            pulse_access(way, rnd % 3);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // edge bookkeeping, mirrors what the DUT sees at the next rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk_in)
    begin
        if (reset_with_request_limit)
        begin
            access_total = 0;
            valid_seen   = 1'b0;
            hit_seen     = '0;
            skip_cycle   = 1'b0;
            mask_q.delete();
            due_q.delete();
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                hit_total[w] = 0;
            end
        end
        else if (skip_cycle)
        begin
            // epoch clear edge, anything rising here is lost
            skip_cycle = 1'b0;
            valid_seen = 1'b0;
            hit_seen   = '0;
        end
        else
        begin
            hit_rise = hit_vec & ~hit_seen;
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                if (hit_rise[w])
                begin
                    hit_total[w]++;
                end
            end
            if (access_valid && !valid_seen)
            begin
                access_total++;
                if (access_total == EPOCH_ACCESSES)
                begin
                    mask_q.push_back(expected_waymask(hit_total));
                    due_q.push_back(edge_count + 1 + NUM_WAYS + 3);
                    access_total = 0;
                    skip_cycle   = 1'b1;
                    for (int w = 0; w < NUM_WAYS; w++)
                    begin
                        hit_total[w] = 0;
                    end
                end
            end
            valid_seen = access_valid;
            hit_seen   = hit_vec;
        end
    end

    // comparison of every mask update against the reference
    always @(negedge clk_in)
    begin
        if (!reset_with_request_limit)
        begin
            if (waymask_update)
            begin
                if (mask_q.size() == 0)
                begin
                    $display("waymask_update pulsed at t=%0t with no epoch pending", $time);
                    error_count++;
                end
                else
                begin
                    exp_mask = mask_q.pop_front();
                    exp_due  = due_q.pop_front();
                    check_count++;
                    if (edge_count != exp_due)
                    begin
                        $display("FAILED t=%0t waymask_update cycle expected=%0d actual=%0d",
                                 $time, exp_due, edge_count);
                        error_count++;
                    end
                    if (suggested_waymask !== exp_mask)
                    begin
                        $display("FAILED t=%0t suggested_waymask expected=%h actual=%h",
                                 $time, exp_mask, suggested_waymask);
                        error_count++;
                    end
                end
            end
            else if (due_q.size() != 0 && edge_count > due_q[0])
            begin
                $display("mask update due at cycle %0d never arrived (t=%0t)", due_q[0], $time);
                error_count++;
                void'(mask_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    initial
    begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        reset_with_request_limit = 1'b1;
        access_valid             = 1'b0;
        hit_vec                  = '0;
        apply_reset(10);

        // idle after reset, mask stays all ones
        check_idle_state();
        repeat (30) @(posedge clk_in);
        check_idle_state();

        // two busy ways, 40 and 24 hits
        for (int i = 0; i < EPOCH_ACCESSES; i++)
        begin
            pulse_access((i % 8 < 5) ? 3 : 9, 0);
        end
        wait_for_updates();

        // hits spread evenly over all ways
        for (int i = 0; i < EPOCH_ACCESSES; i++)
        begin
            pulse_access(i % NUM_WAYS, 0);
        end
        wait_for_updates();

        // held valid and held hit bits count once
        for (int i = 0; i < 8; i++)
        begin
            hold_inputs(1'b1, way_bit(i % 3 + 1), 6);
            hold_inputs(1'b0, '0, 2);
        end
        hold_inputs(1'b0, way_bit(7), 1);
        for (int i = 0; i < 6; i++)
        begin
            hold_inputs(1'b1, way_bit(7), 1);
            hold_inputs(1'b0, way_bit(7), 1);
        end
        hold_inputs(1'b0, '0, 1);
        for (int i = 0; i < EPOCH_ACCESSES - 14; i++)
        begin
            pulse_access(i % 4, 0);
        end
        wait_for_updates();

        // random epochs back to back
        for (int e = 0; e < 10; e++)
        begin
            run_random_epoch(EPOCH_ACCESSES);
        end
        wait_for_updates();

        // reset part way through an epoch, then a full fresh epoch
        run_random_epoch(30);
        apply_reset(3);
        check_idle_state();
        run_random_epoch(EPOCH_ACCESSES);
        wait_for_updates();

        repeat (5) @(posedge clk_in);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
source/autocat_pkg.sv
source/access_epoch_counter.sv
source/way_hit_counters.sv
source/count_sorter.sv
source/partition_selector.sv
source/autocat_top.sv
verif/autocat_tb.sv
